// ==== verilog/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Control flag levels
`define ENABLE  1'b1
`define DISABLE 1'b0

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Register index for instructions without a destination
`define REG_NONE 5'd0

// Byte lanes on the Wishbone data bus
`define BUS_SEL_W 4

`endif

// ==== verilog/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

  typedef enum logic [5:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_LUI, ALU_JAL, ALU_JALR,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
    ALU_SB, ALU_SH, ALU_SW,
    ALU_NOP
  } alu_code_e;

  // Where an ALU operand comes from
  typedef enum logic [1:0] {
    OP_TYPE_NONE,
    OP_TYPE_REG,
    OP_TYPE_IMM,
    OP_TYPE_PC
  } op_type_e;

  typedef struct packed {
    logic [4:0]  src1;
    logic [4:0]  src2;
    logic [4:0]  dst;
    logic [31:0] imm;
    alu_code_e   alu_code;
    op_type_e    op1_type;
    op_type_e    op2_type;
    logic        reg_write;
    logic        is_load;
    logic        is_store;
    logic        is_halt;
  } decoded_t;

  // Master side of the Wishbone classic port
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [31:0]           adr;
    logic [`BUS_SEL_W-1:0] sel;
    logic [31:0]           dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// ==== verilog/decoder.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module decoder (
  input  logic [31:0]      inst,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    dec = '0;
    dec.src1 = `REG_NONE;
    dec.src2 = `REG_NONE;
    dec.dst = `REG_NONE;
    dec.alu_code = ALU_NOP;
    dec.op1_type = OP_TYPE_NONE;
    dec.op2_type = OP_TYPE_NONE;
    dec.reg_write = `DISABLE;
    dec.is_load = `DISABLE;
    dec.is_store = `DISABLE;
    dec.is_halt = `DISABLE;
    case (opcode)
      // Immediate ALU ops with shamt in imm[4:0]
      7'b0010011: begin
        dec.op1_type = OP_TYPE_REG;
        dec.op2_type = OP_TYPE_IMM;
        dec.reg_write = `ENABLE;
        dec.src1 = inst[19:15];
        dec.dst = inst[11:7];
        dec.imm = {{20{inst[31]}}, inst[31:20]};
        case (funct3)
          3'b000: dec.alu_code = ALU_ADD;
          3'b001: dec.alu_code = ALU_SLL;
          3'b010: dec.alu_code = ALU_SLT;
          3'b011: dec.alu_code = ALU_SLTU;
          3'b100: dec.alu_code = ALU_XOR;
          3'b101: dec.alu_code = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: dec.alu_code = ALU_OR;
          3'b111: dec.alu_code = ALU_AND;
        endcase
      end
      7'b0110011: begin
        dec.op1_type = OP_TYPE_REG;
        dec.op2_type = OP_TYPE_REG;
        dec.reg_write = `ENABLE;
        dec.src1 = inst[19:15];
        dec.src2 = inst[24:20];
        dec.dst = inst[11:7];
        case (funct3)
          3'b000: dec.alu_code = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b001: dec.alu_code = ALU_SLL;
          3'b010: dec.alu_code = ALU_SLT;
          3'b011: dec.alu_code = ALU_SLTU;
          3'b100: dec.alu_code = ALU_XOR;
          3'b101: dec.alu_code = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: dec.alu_code = ALU_OR;
          3'b111: dec.alu_code = ALU_AND;
        endcase
      end
      // LUI
      7'b0110111: begin
        dec.op2_type = OP_TYPE_IMM;
        dec.reg_write = `ENABLE;
        dec.dst = inst[11:7];
        dec.imm = {inst[31:12], 12'd0};
        dec.alu_code = ALU_LUI;
      end
      // AUIPC is an add of imm and pc
      7'b0010111: begin
        dec.op1_type = OP_TYPE_IMM;
        dec.op2_type = OP_TYPE_PC;
        dec.reg_write = `ENABLE;
        dec.dst = inst[11:7];
        dec.imm = {inst[31:12], 12'd0};
        dec.alu_code = ALU_ADD;
      end
      // JAL
      7'b1101111: begin
        dec.op2_type = OP_TYPE_PC;
        dec.reg_write = (inst[11:7] != 5'd0);
        dec.dst = inst[11:7];
        dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        dec.alu_code = ALU_JAL;
      end
      // JALR
      7'b1100111: begin
        dec.op1_type = OP_TYPE_REG;
        dec.op2_type = OP_TYPE_PC;
        dec.reg_write = (inst[11:7] != 5'd0);
        dec.src1 = inst[19:15];
        dec.dst = inst[11:7];
        dec.imm = {{20{inst[31]}}, inst[31:20]};
        dec.alu_code = ALU_JALR;
      end
      7'b1100011: begin
        dec.op1_type = OP_TYPE_REG;
        dec.op2_type = OP_TYPE_REG;
        dec.src1 = inst[19:15];
        dec.src2 = inst[24:20];
        dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        case (funct3)
          3'b000: dec.alu_code = ALU_BEQ;
          3'b001: dec.alu_code = ALU_BNE;
          3'b100: dec.alu_code = ALU_BLT;
          3'b101: dec.alu_code = ALU_BGE;
          3'b110: dec.alu_code = ALU_BLTU;
          3'b111: dec.alu_code = ALU_BGEU;
          default: dec.alu_code = ALU_NOP;
        endcase
      end
      // Stores
      7'b0100011: begin
        dec.op1_type = OP_TYPE_REG;
        dec.op2_type = OP_TYPE_IMM;
        dec.is_store = `ENABLE;
        dec.src1 = inst[19:15];
        dec.src2 = inst[24:20];
        dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        case (funct3)
          3'b000: dec.alu_code = ALU_SB;
          3'b001: dec.alu_code = ALU_SH;
          default: dec.alu_code = ALU_SW;
        endcase
      end
      // Loads
      7'b0000011: begin
        dec.op1_type = OP_TYPE_REG;
        dec.op2_type = OP_TYPE_IMM;
        dec.reg_write = `ENABLE;
        dec.is_load = `ENABLE;
        dec.src1 = inst[19:15];
        dec.dst = inst[11:7];
        dec.imm = {{20{inst[31]}}, inst[31:20]};
        case (funct3)
          3'b000: dec.alu_code = ALU_LB;
          3'b001: dec.alu_code = ALU_LH;
          3'b100: dec.alu_code = ALU_LBU;
          3'b101: dec.alu_code = ALU_LHU;
          default: dec.alu_code = ALU_LW;
        endcase
      end
      default: dec.is_halt = `ENABLE;
    endcase
  end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  rv_pkg::decoded_t dec,
  input  logic [31:0]      rs1_val,
  input  logic [31:0]      rs2_val,
  input  logic [31:0]      pc,
  output logic [31:0]      result,
  output logic             taken,
  output logic [31:0]      mem_addr
);
  import rv_pkg::*;

  logic [31:0] op1;
  logic [31:0] op2;

  always_comb begin
    case (dec.op1_type)
      OP_TYPE_REG: op1 = rs1_val;
      OP_TYPE_IMM: op1 = dec.imm;
      OP_TYPE_PC:  op1 = pc;
      default:     op1 = '0;
    endcase
    case (dec.op2_type)
      OP_TYPE_REG: op2 = rs2_val;
      OP_TYPE_IMM: op2 = dec.imm;
      OP_TYPE_PC:  op2 = pc;
      default:     op2 = '0;
    endcase
  end

  // Also the JALR target before the controller clears bit 0
  assign mem_addr = rs1_val + dec.imm;

  always_comb begin
    result = '0;
    taken = 1'b0;
    case (dec.alu_code)
      ALU_ADD:  result = op1 + op2;
      ALU_SUB:  result = op1 - op2;
      ALU_SLL:  result = op1 << op2[4:0];
      ALU_SLT:  result = {31'd0, $signed(op1) < $signed(op2)};
      ALU_SLTU: result = {31'd0, op1 < op2};
      ALU_XOR:  result = op1 ^ op2;
      ALU_SRL:  result = op1 >> op2[4:0];
      ALU_SRA:  result = $signed(op1) >>> op2[4:0];
      ALU_OR:   result = op1 | op2;
      ALU_AND:  result = op1 & op2;
      ALU_LUI:  result = op2;
      // Link address
      ALU_JAL, ALU_JALR: begin
        result = op2 + 32'd4;
        taken = 1'b1;
      end
      ALU_BEQ:  taken = (op1 == op2);
      ALU_BNE:  taken = (op1 != op2);
      ALU_BLT:  taken = ($signed(op1) < $signed(op2));
      ALU_BGE:  taken = ($signed(op1) >= $signed(op2));
      ALU_BLTU: taken = (op1 < op2);
      ALU_BGEU: taken = (op1 >= op2);
      default:  result = mem_addr;
    endcase
  end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rd_addr1,
  input  logic [4:0]  rd_addr2,
  output logic [31:0] rd_data1,
  output logic [31:0] rd_data2,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != 5'd0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 is never written and reads zero
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

// ==== verilog/core_ctrl.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module core_ctrl (
  input  logic             clk,
  input  logic             reset,
  output rv_pkg::wb_req_t  wb_req,
  input  rv_pkg::wb_rsp_t  wb_rsp,
  output logic [31:0]      inst,
  input  rv_pkg::decoded_t dec,
  input  logic [31:0]      alu_result,
  input  logic [31:0]      mem_addr,
  input  logic             taken,
  input  logic [31:0]      rs2_val,
  output logic [31:0]      pc,
  output logic             wr_en,
  output logic [31:0]      wr_data,
  output logic             halted
);
  import rv_pkg::*;

  typedef enum logic [2:0] {FETCH, EXEC, MEM, WB, HALT} state_e;

  state_e                state;
  logic                  req_cyc;
  logic                  req_we;
  logic [31:0]           req_adr;
  logic [`BUS_SEL_W-1:0] req_sel;
  logic [31:0]           req_dat;
  logic [31:0]           load_q;
  logic [`BUS_SEL_W-1:0] acc_sel;
  logic [31:0]           st_data;
  logic [31:0]           ld_shift;
  logic [31:0]           ld_data;
  logic [31:0]           next_pc;

  assign wb_req = '{cyc: req_cyc, stb: req_cyc, we: req_we, adr: req_adr,
                    sel: req_sel, dat: req_dat};

  // Byte lanes and store data for the current access size
  always_comb begin
    case (dec.alu_code)
      ALU_SB, ALU_LB, ALU_LBU: begin
        acc_sel = 4'b0001 << mem_addr[1:0];
        st_data = {4{rs2_val[7:0]}};
      end
      ALU_SH, ALU_LH, ALU_LHU: begin
        acc_sel = 4'b0011 << {mem_addr[1], 1'b0};
        st_data = {2{rs2_val[15:0]}};
      end
      default: begin
        acc_sel = '1;
        st_data = rs2_val;
      end
    endcase
  end

  assign ld_shift = load_q >> {mem_addr[1:0], 3'b000};

  always_comb begin
    case (dec.alu_code)
      ALU_LB:  ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
      ALU_LBU: ld_data = {24'd0, ld_shift[7:0]};
      ALU_LH:  ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
      ALU_LHU: ld_data = {16'd0, ld_shift[15:0]};
      default: ld_data = ld_shift;
    endcase
  end

  always_comb begin
    if (dec.alu_code == ALU_JALR) begin
      next_pc = {mem_addr[31:1], 1'b0};
    end else if (taken) begin
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  assign wr_en = (state == WB) && dec.reg_write;
  assign wr_data = dec.is_load ? ld_data : alu_result;
  assign halted = (state == HALT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH;
      req_cyc <= `DISABLE;
      pc <= `RESET_PC;
    end else begin
      case (state)
        FETCH: begin
          if (!req_cyc) begin
            req_cyc <= `ENABLE;
          end else if (wb_rsp.ack) begin
            req_cyc <= `DISABLE;
            state <= EXEC;
          end
        end
        EXEC: begin
          if (dec.is_halt) begin
            state <= HALT;
          end else if (dec.is_load || dec.is_store) begin
            req_cyc <= `ENABLE;
            state <= MEM;
          end else begin
            state <= WB;
          end
        end
        MEM: begin
          if (wb_rsp.ack) begin
            req_cyc <= `DISABLE;
            state <= WB;
          end
        end
        WB: begin
          pc <= next_pc;
          state <= FETCH;
        end
        // Stays halted until reset
        default: state <= HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      FETCH: begin
        if (!req_cyc) begin
          req_we <= 1'b0;
          req_adr <= pc;
          req_sel <= '1;
        end else if (wb_rsp.ack) begin
          inst <= wb_rsp.dat;
        end
      end
      EXEC: begin
        req_we <= dec.is_store;
        req_adr <= {mem_addr[31:2], 2'b00};
        req_sel <= acc_sel;
        req_dat <= st_data;
      end
      MEM: begin
        if (wb_rsp.ack) begin
          load_q <= wb_rsp.dat;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic            clk,
  input  logic            reset,
  output rv_pkg::wb_req_t wb_req,
  input  rv_pkg::wb_rsp_t wb_rsp,
  output logic            halted
);
  import rv_pkg::*;

  logic [31:0] inst;
  decoded_t    dec;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] pc;
  logic [31:0] alu_result;
  logic        taken;
  logic [31:0] mem_addr;
  logic        wr_en;
  logic [31:0] wr_data;

  core_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .inst       (inst),
    .dec        (dec),
    .alu_result (alu_result),
    .mem_addr   (mem_addr),
    .taken      (taken),
    .rs2_val    (rs2_val),
    .pc         (pc),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .halted     (halted)
  );

  decoder u_decoder (
    .inst (inst),
    .dec  (dec)
  );

  alu u_alu (
    .dec      (dec),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .pc       (pc),
    .result   (alu_result),
    .taken    (taken),
    .mem_addr (mem_addr)
  );

  regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rd_addr1 (dec.src1),
    .rd_addr2 (dec.src2),
    .rd_data1 (rs1_val),
    .rd_data2 (rs2_val),
    .wr_en    (wr_en),
    .wr_addr  (dec.dst),
    .wr_data  (wr_data)
  );

endmodule

// ==== test/bus_checker.sv ====
`timescale 1ns/1ps

module bus_checker (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::wb_req_t wb_req,
  input  rv_pkg::wb_rsp_t wb_rsp,
  input  logic            halted,
  output int              mismatch_count,
  output int              other_count
);
  import rv_pkg::*;

  logic [31:0] golden [512];
  int          n_exp;
  int          idx;
  int          base;
  logic [31:0] last_adr;
  logic        halt_seen;

  initial begin
    $readmemh("test/rv_core_golden.hex", golden);
    n_exp = golden[64];
    idx = 0;
    mismatch_count = 0;
    other_count = 0;
    last_adr = '0;
    halt_seen = 1'b0;
  end

  task automatic compare_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("ERROR %s expected %h actual %h at bus cycle %0d", name, exp_val, act_val, idx);
      mismatch_count++;
    end
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
        if (halt_seen) begin
          $display("Bus cycle to %h issued after halt", wb_req.adr);
          other_count++;
        end else if (idx >= n_exp) begin
          $display("More bus cycles than expected, extra one to %h", wb_req.adr);
          other_count++;
        end else begin
          base = 65 + 4 * idx;
          compare_field("wb_req.we", golden[base], {31'd0, wb_req.we});
          compare_field("wb_req.adr", golden[base + 1], wb_req.adr);
          compare_field("wb_req.sel", golden[base + 2], {28'd0, wb_req.sel});
          // Store data on writes and returned data on reads
          if (wb_req.we) begin
            compare_field("wb_req.dat", golden[base + 3], wb_req.dat);
          end else begin
            compare_field("wb_rsp.dat", golden[base + 3], wb_rsp.dat);
          end
          idx++;
        end
        last_adr = wb_req.adr;
      end
      if (halt_seen && halted !== 1'b1) begin
        $display("The halted output dropped before reset");
        other_count++;
      end
      if (halted && !halt_seen) begin
        halt_seen = 1'b1;
        if (idx != n_exp) begin
          $display("Core halted after %0d bus cycles but %0d were expected", idx, n_exp);
          other_count++;
        end
        compare_field("halt_pc", golden[65 + 4 * n_exp], last_adr);
      end
    end
  end

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  logic        clk;
  logic        reset;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        halted;
  logic [31:0] golden [512];
  logic [31:0] mem [64];
  logic [31:0] rng_state;
  int          wait_left;
  logic        busy;
  int          mismatch_count;
  int          other_count;
  longint      limit_ns;

  rv_core dut (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .halted (halted)
  );

  bus_checker u_bus_checker (
    .clk            (clk),
    .reset          (reset),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .halted         (halted),
    .mismatch_count (mismatch_count),
    .other_count    (other_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    wb_rsp = '0;
    busy = 1'b0;
    wait_left = 0;
    rng_state = 32'heb1a_671d;
    $readmemh("test/rv_core_golden.hex", golden);
    for (int i = 0; i < 64; i++) begin
      mem[i] = golden[i];
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    wait (halted === 1'b1);
    // Give a stray bus cycle after halt time to show up
    repeat (8) @(posedge clk);
    @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Wishbone slave with zero to three wait states per cycle
  always @(negedge clk) begin
    if (reset) begin
      wb_rsp = '0;
      busy = 1'b0;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!busy) begin
        busy = 1'b1;
        rng_state = xorshift32(rng_state);
        wait_left = rng_state[1:0];
      end
      if (wait_left == 0) begin
        busy = 1'b0;
        wb_rsp.ack = 1'b1;
        wb_rsp.dat = mem[wb_req.adr[7:2]];
        if (wb_req.we) begin
          for (int b = 0; b < 4; b++) begin
            if (wb_req.sel[b]) begin
              mem[wb_req.adr[7:2]][8*b +: 8] = wb_req.dat[8*b +: 8];
            end
          end
        end
      end else begin
        wait_left--;
      end
    end
  end

  initial begin
    #1;
    limit_ns = longint'(golden[64]) * (4 + 4) * 20 + 16 * 20;
    #(limit_ns);
    $display("Timeout: the core did not halt in time");
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== test/rv_core_golden.hex ====
// Words 0-63: program and data image. Then the record count N,
// then N records of we adr sel dat (dat is read data for reads), then the halt PC
800000B7 FF000113 40215193 40118233 0C000513 00452023 004122B3 00223333
00431313 0062E3B3 0F03C393 007500A3 00001417 00851323 00150583 00655603
00C586B3 00D52423 00628463 00629463 00100693 00514463 00100693 00516463
00225463 00100693 0022F463 00C0076F 00100693 00100693 01570067 00100693
00100693 00E52623 00051123 00051803 00154883 01185933 411859B3 01394A33
01287AB3 01452823 01552A23 00852B83 017509A3 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000035
0 00000000 F 800000B7  0 00000004 F FF000113
0 00000008 F 40215193  0 0000000C F 40118233
0 00000010 F 0C000513  0 00000014 F 00452023
1 000000C0 F 7FFFFFFC  0 00000018 F 004122B3
0 0000001C F 00223333  0 00000020 F 00431313
0 00000024 F 0062E3B3  0 00000028 F 0F03C393
0 0000002C F 007500A3  1 000000C0 2 E1E1E1E1
0 00000030 F 00001417  0 00000034 F 00851323
1 000000C4 C 10301030  0 00000038 F 00150583
0 000000C0 2 7FFFE1FC  0 0000003C F 00655603
0 000000C4 C 10300000  0 00000040 F 00C586B3
0 00000044 F 00D52423  1 000000C8 F 00001011
0 00000048 F 00628463  0 0000004C F 00629463
0 00000054 F 00514463  0 0000005C F 00516463
0 00000060 F 00225463  0 00000068 F 0022F463
0 0000006C F 00C0076F  0 00000078 F 01570067
0 00000084 F 00E52623  1 000000CC F 00000070
0 00000088 F 00051123  1 000000C0 C 00000000
0 0000008C F 00051803  0 000000C0 3 0000E1FC
0 00000090 F 00154883  0 000000C0 2 0000E1FC
0 00000094 F 01185933  0 00000098 F 411859B3
0 0000009C F 01394A33  0 000000A0 F 01287AB3
0 000000A4 F 01452823  1 000000D0 F 80000000
0 000000A8 F 01552A23  1 000000D4 F 7FFFE0FC
0 000000AC F 00852B83  0 000000C8 F 00001011
0 000000B0 F 017509A3  1 000000D0 8 11111111
0 000000B4 F 00000000
000000B4

// ==== rv_core.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/decoder.sv
verilog/alu.sv
verilog/regfile.sv
verilog/core_ctrl.sv
verilog/rv_core.sv
test/bus_checker.sv
test/tb_rv_core.sv
